// File: design/median_pkg.sv
// median filter shared sizes
// frame geometry, window geometry and sorter depth
`default_nettype none

package median_pkg;

  // pixel format
  localparam int PIX_W = 8;
  localparam int PIX_MAX = 255;

  // 8x8 frame in a 64-word memory
  localparam int IMG_DIM = 8;
  localparam int ADDR_W = 6;
  localparam int COL_W = 3;

  // 7x7 window, median sits in the middle of 49 sorted cells
  localparam int WIN = 7;
  localparam int WIN_HALF = 3;
  localparam int WIN_AREA = 49;
  localparam int MED_IDX = 24;

endpackage

`default_nettype wire

// File: design/sort_cell.sv
// sort cell
// one slot of the ordered list; on an insert/delete pair it takes a
// neighbour's value or the inserted value so the chain stays sorted
`timescale 1ns/1ps
`default_nettype none

module sort_cell (
  input  wire                              clk,
  input  wire                              RST,
  input  wire  [median_pkg::PIX_W-1:0]     ins,
  input  wire  [median_pkg::PIX_W-1:0]     del,
  input  wire  [median_pkg::PIX_W-1:0]     prev_val,
  input  wire  [median_pkg::PIX_W-1:0]     next_val,
  output logic [median_pkg::PIX_W-1:0]     val
);
  import median_pkg::*;

  logic [PIX_W-1:0] val_next;

  always_comb begin
    val_next = val;
    if (ins < del) begin
      // cells in (ins, del] move up one place
      if (val > ins && val <= del) begin
        val_next = (prev_val > ins) ? prev_val : ins;
      end
    end else if (ins > del) begin
      // cells in [del, ins) move down one place
      if (val < ins && val >= del) begin
        val_next = (next_val < ins) ? next_val : ins;
      end
    end
  end

  always_ff @(posedge clk or posedge RST) begin
    if (RST) begin
      val <= PIX_W'(PIX_MAX);
    end else begin
      val <= val_next;
    end
  end

endmodule

`default_nettype wire

// File: design/window_sorter.sv
// window sorter
// 49 ordered cells holding the window pixels in ascending order
// one delete/insert pair per cycle, median read from the middle cell
`timescale 1ns/1ps
`default_nettype none

module window_sorter (
  input  wire                              clk,
  input  wire                              RST,
  input  wire                              sort_en,
  input  wire  [median_pkg::PIX_W-1:0]     sort_ins,
  input  wire  [median_pkg::PIX_W-1:0]     sort_del,
  output logic [median_pkg::PIX_W-1:0]     median
);
  import median_pkg::*;

  logic [PIX_W-1:0] ins_eff;
  logic [PIX_W-1:0] del_eff;
  // link[g+1] is cell g, the two ends are fixed bounds
  wire  [PIX_W-1:0] link [WIN_AREA + 2];

  // equal insert and delete leave every cell alone
  assign ins_eff = sort_en ? sort_ins : PIX_W'(PIX_MAX);
  assign del_eff = sort_en ? sort_del : PIX_W'(PIX_MAX);

  assign link[0]            = '0;
  assign link[WIN_AREA + 1] = PIX_W'(PIX_MAX);

  for (genvar g = 0; g < WIN_AREA; g++) begin : g_cell
    sort_cell u_cell (
      .clk      (clk),
      .RST      (RST),
      .ins      (ins_eff),
      .del      (del_eff),
      .prev_val (link[g]),
      .next_val (link[g + 2]),
      .val      (link[g + 1])
    );
  end

  assign median = link[MED_IDX + 1];

endmodule

`default_nettype wire

// File: design/frame_buffer.sv
// frame memory
// 64x8 single-port synchronous RAM, read data one cycle after the address
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
  input  wire                              clk,
  input  wire                              mem_we,
  input  wire  [median_pkg::ADDR_W-1:0]    mem_addr,
  input  wire  [median_pkg::PIX_W-1:0]     wdata,
  output logic [median_pkg::PIX_W-1:0]     rd_data
);
  import median_pkg::*;

  logic [PIX_W-1:0] mem [IMG_DIM * IMG_DIM];

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr] <= wdata;
    end
    rd_data <= mem[mem_addr];
  end

endmodule

`default_nettype wire

// File: design/row_reorder.sv
// row reorder buffer
// collects one row of medians by column, since left-going rows arrive
// right to left, then replays the row as a burst from column 0 upward
`timescale 1ns/1ps
`default_nettype none

module row_reorder (
  input  wire                              clk,
  input  wire                              RST,
  input  wire                              med_we,
  input  wire  [median_pkg::COL_W-1:0]     med_col,
  input  wire  [median_pkg::PIX_W-1:0]     median,
  output logic                             out_valid,
  output logic [median_pkg::PIX_W-1:0]     dout
);
  import median_pkg::*;

  logic [PIX_W-1:0] row_mem [IMG_DIM];
  logic [COL_W-1:0] wr_cnt;
  logic [COL_W-1:0] rd_cnt;

  always_ff @(posedge clk) begin
    if (med_we) begin
      row_mem[med_col] <= median;
    end
  end

  always_ff @(posedge clk or posedge RST) begin
    if (RST) begin
      wr_cnt    <= '0;
      rd_cnt    <= '0;
      out_valid <= 1'b0;
    end else begin
      if (med_we) begin
        wr_cnt <= wr_cnt + 1'b1;
      end
      // row complete, burst starts next cycle
      if (med_we && wr_cnt == COL_W'(IMG_DIM - 1)) begin
        out_valid <= 1'b1;
        rd_cnt    <= '0;
      end else if (out_valid) begin
        rd_cnt <= rd_cnt + 1'b1;
        if (rd_cnt == COL_W'(IMG_DIM - 1)) begin
          out_valid <= 1'b0;
        end
      end
    end
  end

  assign dout = row_mem[rd_cnt];

endmodule

`default_nettype wire

// File: design/scan_controller.sv
// scan controller
// loads a frame, then walks the 7x7 window in a snake path over it
// keeps the window register, zeroes pixels outside the image and feeds
// delete/insert pairs to the sorter; hands each median on with its column
`timescale 1ns/1ps
`default_nettype none

module scan_controller (
  input  wire                              clk,
  input  wire                              RST,
  input  wire                              in_en,
  input  wire  [median_pkg::PIX_W-1:0]     rd_data,
  input  wire  [median_pkg::PIX_W-1:0]     median,
  output logic [median_pkg::ADDR_W-1:0]    mem_addr,
  output logic                             mem_we,
  output logic                             sort_en,
  output logic [median_pkg::PIX_W-1:0]     sort_ins,
  output logic [median_pkg::PIX_W-1:0]     sort_del,
  output logic                             med_we,
  output logic [median_pkg::COL_W-1:0]     med_col,
  output logic [median_pkg::PIX_W-1:0]     med_data,
  output logic                             busy
);
  import median_pkg::*;

  localparam logic [2:0] S_IDLE  = 3'd0;
  localparam logic [2:0] S_FILL  = 3'd1;
  localparam logic [2:0] S_RIGHT = 3'd2;
  localparam logic [2:0] S_DOWN  = 3'd3;
  localparam logic [2:0] S_LEFT  = 3'd4;

  logic [2:0]        state;
  logic [5:0]        rc;
  logic [5:0]        step_len;
  logic              step_end;
  logic              fetch;
  logic              at_edge;
  logic [COL_W-1:0]  cx;
  logic [COL_W-1:0]  cy;
  logic [COL_W-1:0]  fc;
  logic [COL_W-1:0]  fr;
  logic [COL_W-1:0]  off_x;
  logic [COL_W-1:0]  off_y;
  logic [4:0]        px;
  logic [4:0]        py;
  logic [ADDR_W-1:0] wr_ptr;
  logic              fetch_q;
  logic              inside_q;
  logic [COL_W-1:0]  idx_q;
  logic [5:0]        base;
  logic [PIX_W-1:0]  new_pix;
  logic [PIX_W-1:0]  old_pix;
  logic              med_pend;
  logic [COL_W-1:0]  col_pend;
  logic [PIX_W-1:0]  win [WIN_AREA];

  // reads per step, then two cycles of memory and sorter latency
  assign step_len = (state == S_FILL) ? 6'(WIN_AREA) : 6'(WIN);
  assign fetch    = (state != S_IDLE) && (rc < step_len);
  assign step_end = (state != S_IDLE) && (rc == step_len + 6'd1);
  assign at_edge  = (state == S_LEFT) ? (cx == '0) : (cx == COL_W'(IMG_DIM - 1));

  // window offset of the pixel being fetched
  always_comb begin
    off_x = rc[COL_W-1:0];
    off_y = rc[COL_W-1:0];
    case (state)
      S_FILL: begin
        off_x = fc;
        off_y = fr;
      end
      S_RIGHT: off_x = COL_W'(WIN - 1);
      S_LEFT:  off_x = '0;
      S_DOWN:  off_y = COL_W'(WIN - 1);
      default: begin
      end
    endcase
  end

  // negative coordinates wrap above IMG_DIM, so one compare covers both sides
  assign px = {2'b00, cx} + {2'b00, off_x} - 5'(WIN_HALF);
  assign py = {2'b00, cy} + {2'b00, off_y} - 5'(WIN_HALF);

  assign mem_addr = (state == S_IDLE) ? wr_ptr : {py[COL_W-1:0], px[COL_W-1:0]};
  assign mem_we   = (state == S_IDLE) && !busy && in_en;

  // leaving pixel of the row or column being replaced
  assign base    = 6'(idx_q) * 6'(WIN);
  assign new_pix = inside_q ? rd_data : '0;
  always_comb begin
    case (state)
      S_RIGHT: old_pix = win[base];
      S_LEFT:  old_pix = win[base + 6'(WIN - 1)];
      S_DOWN:  old_pix = win[idx_q];
      default: old_pix = win[0];
    endcase
  end

  always_ff @(posedge clk or posedge RST) begin
    if (RST) begin
      state  <= S_IDLE;
      rc     <= '0;
      cx     <= '0;
      cy     <= '0;
      fc     <= '0;
      fr     <= '0;
      wr_ptr <= '0;
      busy   <= 1'b0;
    end else if (state == S_IDLE) begin
      if (!busy && in_en) begin
        wr_ptr <= wr_ptr + 1'b1;
        if (wr_ptr == ADDR_W'(IMG_DIM * IMG_DIM - 1)) begin
          busy  <= 1'b1;
          state <= S_FILL;
          rc    <= '0;
          cx    <= '0;
          cy    <= '0;
          fc    <= '0;
          fr    <= '0;
        end
      end else if (med_we) begin
        // last median of the frame is on its way out
        busy <= 1'b0;
      end
    end else begin
      rc <= rc + 1'b1;
      if (state == S_FILL && fetch) begin
        fc <= (fc == COL_W'(WIN - 1)) ? '0 : fc + 1'b1;
        if (fc == COL_W'(WIN - 1)) begin
          fr <= fr + 1'b1;
        end
      end
      if (step_end) begin
        rc <= '0;
        if (state == S_DOWN) begin
          // even rows run right, odd rows run left
          state <= cy[0] ? S_LEFT : S_RIGHT;
          cx    <= cy[0] ? cx - 1'b1 : cx + 1'b1;
        end else if (!at_edge) begin
          state <= (state == S_LEFT) ? S_LEFT : S_RIGHT;
          cx    <= (state == S_LEFT) ? cx - 1'b1 : cx + 1'b1;
        end else if (cy == COL_W'(IMG_DIM - 1)) begin
          state <= S_IDLE;
        end else begin
          state <= S_DOWN;
          cy    <= cy + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or posedge RST) begin
    if (RST) begin
      fetch_q  <= 1'b0;
      sort_en  <= 1'b0;
      med_pend <= 1'b0;
      med_we   <= 1'b0;
    end else begin
      fetch_q  <= fetch;
      sort_en  <= fetch_q;
      med_pend <= step_end;
      med_we   <= med_pend;
    end
  end

  always_ff @(posedge clk) begin
    idx_q    <= rc[COL_W-1:0];
    inside_q <= (px < 5'(IMG_DIM)) && (py < 5'(IMG_DIM));
    sort_ins <= new_pix;
    sort_del <= old_pix;
    col_pend <= cx;
    med_col  <= col_pend;
    med_data <= median;
  end

  // starts out equal to the sorter contents after reset
  always_ff @(posedge clk or posedge RST) begin
    if (RST) begin
      for (int k = 0; k < WIN_AREA; k++) begin
        win[k] <= PIX_W'(PIX_MAX);
      end
    end else if (fetch_q) begin
      case (state)
        S_FILL: begin
          for (int k = 0; k < WIN_AREA - 1; k++) begin
            win[k] <= win[k + 1];
          end
          win[WIN_AREA - 1] <= new_pix;
        end
        S_RIGHT: begin
          for (int c = 0; c < WIN - 1; c++) begin
            win[base + c] <= win[base + c + 1];
          end
          win[base + WIN - 1] <= new_pix;
        end
        S_LEFT: begin
          for (int c = WIN - 1; c > 0; c--) begin
            win[base + c] <= win[base + c - 1];
          end
          win[base] <= new_pix;
        end
        S_DOWN: begin
          for (int r = 0; r < WIN - 1; r++) begin
            win[r * WIN + idx_q] <= win[(r + 1) * WIN + idx_q];
          end
          win[(WIN - 1) * WIN + idx_q] <= new_pix;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/median_filter.sv
// 7x7 median filter, top level
// loads an 8x8 frame, filters it with a snake-scanned window and
// returns the medians in raster order, one row per burst
`timescale 1ns/1ps
`default_nettype none

module median_filter (
  input  wire                              clk,
  input  wire                              RST,
  input  wire  [median_pkg::PIX_W-1:0]     din,
  input  wire                              in_en,
  output logic                             busy,
  output logic                             out_valid,
  output logic [median_pkg::PIX_W-1:0]     dout
);
  import median_pkg::*;

  logic [ADDR_W-1:0] mem_addr;
  logic              mem_we;
  logic [PIX_W-1:0]  rd_data;
  logic              sort_en;
  logic [PIX_W-1:0]  sort_ins;
  logic [PIX_W-1:0]  sort_del;
  logic [PIX_W-1:0]  sort_median;
  logic              med_we;
  logic [COL_W-1:0]  med_col;
  logic [PIX_W-1:0]  med_data;

  scan_controller u_ctrl (
    .clk      (clk),
    .RST      (RST),
    .in_en    (in_en),
    .rd_data  (rd_data),
    .median   (sort_median),
    .mem_addr (mem_addr),
    .mem_we   (mem_we),
    .sort_en  (sort_en),
    .sort_ins (sort_ins),
    .sort_del (sort_del),
    .med_we   (med_we),
    .med_col  (med_col),
    .med_data (med_data),
    .busy     (busy)
  );

  frame_buffer u_mem (
    .clk      (clk),
    .mem_we   (mem_we),
    .mem_addr (mem_addr),
    .wdata    (din),
    .rd_data  (rd_data)
  );

  window_sorter u_sort (
    .clk      (clk),
    .RST      (RST),
    .sort_en  (sort_en),
    .sort_ins (sort_ins),
    .sort_del (sort_del),
    .median   (sort_median)
  );

  row_reorder u_reorder (
    .clk       (clk),
    .RST       (RST),
    .med_we    (med_we),
    .med_col   (med_col),
    .median    (med_data),
    .out_valid (out_valid),
    .dout      (dout)
  );

endmodule

`default_nettype wire

// File: tb/median_filter_assertions.sv
// median filter port checks
// bound to the top level; watches reset, burst length and output start
`timescale 1ns/1ps
`default_nettype none

module median_filter_assertions (
  input wire clk,
  input wire RST,
  input wire busy,
  input wire out_valid
);
  import median_pkg::*;

  int   fail_count = 0;
  logic seen_busy;

  // set once the first frame has been loaded
  always_ff @(posedge clk or posedge RST) begin
    if (RST) begin
      seen_busy <= 1'b0;
    end else if (busy) begin
      seen_busy <= 1'b1;
    end
  end

  valid_low_in_reset: assert property (@(posedge clk) RST |-> !out_valid)
    else begin
      fail_count++;
      $error("out_valid high while RST is asserted");
    end

  burst_not_too_long: assert property (
    @(posedge clk) disable iff (RST) out_valid [*IMG_DIM] |=> !out_valid)
    else begin
      fail_count++;
      $error("out_valid burst longer than one row");
    end

  valid_after_busy: assert property (
    @(posedge clk) disable iff (RST) out_valid |-> seen_busy)
    else begin
      fail_count++;
      $error("out_valid seen before any frame was loaded");
    end

endmodule

bind median_filter median_filter_assertions u_assert (
  .clk       (clk),
  .RST       (RST),
  .busy      (busy),
  .out_valid (out_valid)
);

`default_nettype wire

// File: tb/median_filter_tb.sv
// median filter testbench
// loads a quadrant frame from the data file and then a flat 255 frame,
// keeps in_en busy with random pixels while filtering, checks all medians
`timescale 1ns/1ps
`default_nettype none

module median_filter_tb;
  import median_pkg::*;

  localparam int NUM_PIX = IMG_DIM * IMG_DIM;
  // two frames of loading plus the slowest possible step per window
  localparam int TIMEOUT_CYCLES = 2 * (NUM_PIX + NUM_PIX * (WIN_AREA + 3)) + 200;
  localparam logic [31:0] SEED = 32'h3b73d6cf;

  logic             clk;
  logic             RST;
  logic [PIX_W-1:0] din;
  logic             in_en;
  logic             busy;
  logic             out_valid;
  logic [PIX_W-1:0] dout;

  // even entries are input pixels and odd entries the expected medians
  logic [PIX_W-1:0] testdata [2 * NUM_PIX];
  logic [PIX_W-1:0] results [$];
  int err_count = 0;
  int run_len = 0;
  int burst_count = 0;
  int cycles = 0;

  median_filter uut (
    .clk       (clk),
    .RST       (RST),
    .din       (din),
    .in_en     (in_en),
    .busy      (busy),
    .out_valid (out_valid),
    .dout      (dout)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // watchdog
  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: frames not finished after %0d cycles", cycles);
    $display("Test FAILED");
    $finish;
  end

  // output monitor sampled mid-cycle
  initial begin
    forever begin
      @(negedge clk);
      if (out_valid) begin
        results.push_back(dout);
        run_len++;
      end else if (run_len != 0) begin
        assert (run_len == IMG_DIM) else begin
          err_count++;
          $display("Fail out_valid burst length: got 0x%0h expected 0x%0h", run_len, IMG_DIM);
        end
        burst_count++;
        run_len = 0;
      end
    end
  end

  task automatic load_frame(input bit all_max);
    for (int i = 0; i < NUM_PIX; i++) begin
      in_en = 1'b1;
      din   = all_max ? PIX_W'(PIX_MAX) : testdata[2 * i];
      @(negedge clk);
    end
  endtask

  // input must be ignored while the frame is filtered
  task automatic drive_while_busy();
    assert (busy) else begin
      err_count++;
      $display("Fail busy after frame load: got 0x%0h expected 0x1", busy);
    end
    while (busy) begin
      in_en = 1'b1;
      din   = PIX_W'($urandom);
      @(negedge clk);
    end
    in_en = 1'b0;
  endtask

  task automatic wait_for_results(input int count);
    while (results.size() < count) begin
      @(posedge clk);
    end
    repeat (2 * IMG_DIM) @(posedge clk);
    assert (results.size() == count) else begin
      err_count++;
      $display("Fail result count: got 0x%0h expected 0x%0h", results.size(), count);
    end
  endtask

  // rows or columns of the window that lie inside the image
  function automatic int window_span(input int p);
    int lo;
    int hi;
    lo = (p - WIN_HALF < 0) ? 0 : p - WIN_HALF;
    hi = (p + WIN_HALF > IMG_DIM - 1) ? IMG_DIM - 1 : p + WIN_HALF;
    return hi - lo + 1;
  endfunction

  // on a flat frame 255 wins once more than half the window is inside
  function automatic logic [PIX_W-1:0] flat_median(input int r, input int c);
    return (window_span(r) * window_span(c) > WIN_AREA / 2) ? PIX_W'(PIX_MAX) : '0;
  endfunction

  task automatic check_frame(input bit all_max);
    logic [PIX_W-1:0] exp_val;
    for (int i = 0; i < NUM_PIX && i < results.size(); i++) begin
      exp_val = all_max ? flat_median(i / IMG_DIM, i % IMG_DIM) : testdata[2 * i + 1];
      assert (results[i] == exp_val) else begin
        err_count++;
        $display("Fail dout at row %0d col %0d: got 0x%02h expected 0x%02h",
                 i / IMG_DIM, i % IMG_DIM, results[i], exp_val);
      end
    end
    results.delete();
  endtask

  initial begin
    RST   = 1'b1;
    in_en = 1'b0;
    din   = '0;
    void'($urandom(SEED));
    $readmemh("tb/median_testdata.txt", testdata);
    repeat (5) @(posedge clk);
    @(negedge clk);
    RST = 1'b0;
    @(negedge clk);
    assert (!busy && !out_valid) else begin
      err_count++;
      $display("Fail after reset: busy 0x%0h out_valid 0x%0h expected 0x0", busy, out_valid);
    end

    // frame 1 from the data file
    load_frame(1'b0);
    drive_while_busy();
    wait_for_results(NUM_PIX);
    check_frame(1'b0);

    // frame 2 with no reset in between
    @(negedge clk);
    load_frame(1'b1);
    drive_while_busy();
    wait_for_results(NUM_PIX);
    check_frame(1'b1);

    assert (burst_count == 2 * IMG_DIM) else begin
      err_count++;
      $display("Fail burst count: got 0x%0h expected 0x%0h", burst_count, 2 * IMG_DIM);
    end

    $display("errors: %0d check failures, %0d assertion failures",
             err_count, uut.u_assert.fail_count);
    if (err_count == 0 && uut.u_assert.fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: median_filter.f
design/median_pkg.sv
design/sort_cell.sv
design/window_sorter.sv
design/frame_buffer.sv
design/row_reorder.sv
design/scan_controller.sv
design/median_filter.sv
tb/median_filter_assertions.sv
tb/median_filter_tb.sv

// File: tb/median_testdata.txt
// din expected_median, one pixel per line in raster order
// quadrants 30 90 / 60 c0, pixels outside the image count as 0
30 00
30 00
30 00
30 30
90 30
90 00
90 00
90 00
30 00
30 30
30 30
30 30
90 30
90 30
90 30
90 00
30 00
30 30
30 30
30 60
90 60
90 60
90 60
90 00
30 30
30 30
30 60
30 60
90 90
90 90
90 90
90 90
60 30
60 30
60 60
60 60
c0 90
c0 90
c0 90
c0 90
60 00
60 30
60 60
60 60
c0 60
c0 60
c0 60
c0 00
60 00
60 30
60 60
60 60
c0 60
c0 60
c0 30
c0 00
60 00
60 00
60 00
60 60
c0 60
c0 00
c0 00
c0 00
